// ==== dbg_ahb_asserts.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_ahb_asserts (
  input logic                       HCLK,
  input logic                       biu_clk,
  input logic                       ahb_rstn,
  input logic [1:0]                 HTRANS,
  input logic [`DBG_AHB_ADDR_W-1:0] HADDR,
  input logic                       HWRITE,
  input logic [2:0]                 HSIZE,
  input logic                       HREADY,
  input logic                       biu_strb,
  input logic                       biu_rdy
);

  // Count of failed assertions, read by the testbench at the end
  int unsigned violation_count = 0;

  // High from the edge after NONSEQ until the acknowledge edge
  logic in_data;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      in_data <= 1'b0;
    end else if (HTRANS == `HTRANS_NONSEQ) begin
      in_data <= 1'b1;
    end else if (HREADY) begin
      in_data <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // AHB side
  ////////////////////////////////////////////////////////////////////////////

  // Single transfers only
  nonseq_one_cycle: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    (HTRANS == `HTRANS_NONSEQ) |=> (HTRANS != `HTRANS_NONSEQ))
    else begin
      violation_count = violation_count + 1;
      $error("NONSEQ held for two consecutive cycles");
    end

  // Address-phase signals frozen through the data phase
  addr_stable: assert property (@(posedge HCLK) disable iff (!ahb_rstn)
    in_data |-> ($stable(HADDR) && $stable(HWRITE) && $stable(HSIZE)))
    else begin
      violation_count = violation_count + 1;
      $error("HADDR, HWRITE or HSIZE changed before the acknowledge");
    end

  ////////////////////////////////////////////////////////////////////////////
  // Debug side
  ////////////////////////////////////////////////////////////////////////////

  rdy_drops: assert property (@(posedge biu_clk) disable iff (!ahb_rstn)
    (biu_strb && biu_rdy) |=> !biu_rdy)
    else begin
      violation_count = violation_count + 1;
      $error("biu_rdy still high after an accepted strobe");
    end

endmodule

// ==== dbg_ahb_bridge.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_ahb_bridge (
  // Debug side
  input  logic                       biu_clk,
  input  logic [`DBG_AHB_ADDR_W-1:0] biu_addr,
  input  logic [`DBG_AHB_DATA_W-1:0] biu_wdata,
  input  logic                       biu_write,
  input  logic [3:0]                 biu_word_size,
  input  logic                       biu_strb,
  output logic                       biu_rdy,
  output logic [`DBG_AHB_DATA_W-1:0] biu_rdata,
  output logic                       biu_err,
  // AHB-Lite master side
  input  logic                       HCLK,
  output logic [`DBG_AHB_ADDR_W-1:0] HADDR,
  output logic                       HWRITE,
  output logic [2:0]                 HSIZE,
  output logic [1:0]                 HTRANS,
  output logic [`DBG_AHB_DATA_W-1:0] HWDATA,
  input  logic [`DBG_AHB_DATA_W-1:0] HRDATA,
  input  logic                       HREADY,
  input  logic                       HRESP,
  // Shared asynchronous reset
  input  logic                       ahb_rstn
);

  // Debug domain request
  logic                   req_load;
  dbg_ahb_pkg::biu_req_t  req_biu;
  // HCLK domain request
  logic                   req_valid;
  dbg_ahb_pkg::biu_req_t  req_hclk;
  // Bus acknowledge and its context
  logic                   ack;
  dbg_ahb_pkg::ahb_addr_t addr_rec;
  logic                   err;
  // Response in HCLK, then back in biu_clk
  logic                   rsp_valid_hclk;
  dbg_ahb_pkg::biu_rsp_t  rsp_hclk;
  logic                   rsp_valid_biu;
  dbg_ahb_pkg::biu_rsp_t  rsp_biu;

  dbg_biu_front u_front (
    .biu_clk       (biu_clk),
    .ahb_rstn      (ahb_rstn),
    .biu_addr      (biu_addr),
    .biu_wdata     (biu_wdata),
    .biu_write     (biu_write),
    .biu_word_size (biu_word_size),
    .biu_strb      (biu_strb),
    .biu_rdy       (biu_rdy),
    .biu_rdata     (biu_rdata),
    .biu_err       (biu_err),
    .req_load      (req_load),
    .req           (req_biu),
    .rsp_valid     (rsp_valid_biu),
    .rsp           (rsp_biu)
  );

  // biu_clk to HCLK
  dbg_toggle_xfer #(
    .payload_t (dbg_ahb_pkg::biu_req_t)
  ) u_req_xfer (
    .src_clk   (biu_clk),
    .dst_clk   (HCLK),
    .ahb_rstn  (ahb_rstn),
    .src_load  (req_load),
    .src_data  (req_biu),
    .dst_valid (req_valid),
    .dst_data  (req_hclk)
  );

  dbg_ahb_master u_master (
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .req_valid (req_valid),
    .req       (req_hclk),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HRESP     (HRESP),
    .ack       (ack),
    .addr_rec  (addr_rec),
    .err       (err)
  );

  dbg_rdata_align u_align (
    .HCLK      (HCLK),
    .ahb_rstn  (ahb_rstn),
    .ack       (ack),
    .addr_rec  (addr_rec),
    .err       (err),
    .HRDATA    (HRDATA),
    .rsp_valid (rsp_valid_hclk),
    .rsp       (rsp_hclk)
  );

  // HCLK back to biu_clk
  dbg_toggle_xfer #(
    .payload_t (dbg_ahb_pkg::biu_rsp_t)
  ) u_rsp_xfer (
    .src_clk   (HCLK),
    .dst_clk   (biu_clk),
    .ahb_rstn  (ahb_rstn),
    .src_load  (rsp_valid_hclk),
    .src_data  (rsp_hclk),
    .dst_valid (rsp_valid_biu),
    .dst_data  (rsp_biu)
  );

endmodule

// ==== dbg_ahb_clkgen.sv ====
`timescale 1ns/1ps

module dbg_ahb_clkgen (
  output logic HCLK,
  output logic biu_clk,
  output logic ahb_rstn
);

  // Half periods in ns
  localparam real HCLK_HALF = 2.0;
  localparam real BIU_HALF  = 5.0;

  // Bus clock, 4 ns period
  initial begin
    HCLK = 1'b0;
    forever #(HCLK_HALF) HCLK = ~HCLK;
  end

  // Debug clock, 10 ns period and unrelated to HCLK
  initial begin
    biu_clk = 1'b0;
    forever #(BIU_HALF) biu_clk = ~biu_clk;
  end

  // Reset held for 10 HCLK cycles, released on a falling edge
  initial begin
    ahb_rstn = 1'b0;
    repeat (10) @(posedge HCLK);
    @(negedge HCLK);
    ahb_rstn = 1'b1;
  end

endmodule

// ==== dbg_ahb_macros.svh ====
`ifndef DBG_AHB_MACROS_SVH
`define DBG_AHB_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Address bus width of the AHB-Lite master port
`define DBG_AHB_ADDR_W 32

// Data bus width, fixed at one 32-bit word
`define DBG_AHB_DATA_W 32

// Lane order, 1 puts byte 0 on bits 7:0
`define DBG_AHB_LITTLE_ENDIAN 1

////////////////////////////////////////////////////////////////////////////
// AHB-Lite encodings
////////////////////////////////////////////////////////////////////////////

// HTRANS codes, only IDLE and NONSEQ are ever issued
`define HTRANS_IDLE   2'b00
`define HTRANS_NONSEQ 2'b10

// HSIZE codes for the three supported access sizes
`define HSIZE_BYTE  3'b000
`define HSIZE_HWORD 3'b001
`define HSIZE_WORD  3'b010

`endif

// ==== dbg_ahb_master.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_ahb_master (
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  input  logic                       req_valid,
  input  dbg_ahb_pkg::biu_req_t      req,
  output logic [`DBG_AHB_ADDR_W-1:0] HADDR,
  output logic                       HWRITE,
  output logic [2:0]                 HSIZE,
  output logic [1:0]                 HTRANS,
  output logic [`DBG_AHB_DATA_W-1:0] HWDATA,
  input  logic                       HREADY,
  input  logic                       HRESP,
  output logic                       ack,
  output dbg_ahb_pkg::ahb_addr_t     addr_rec,
  output logic                       err
);

  // One single transfer at a time
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  logic [1:0] rst_sync;
  logic       rstn;

  state_t     state;
  // Request seen while the bus was still busy
  logic       pending;
  logic       start;
  logic       in_data;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rstn = rst_sync[1];

  ////////////////////////////////////////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////////////////////////////////////////

  assign start   = (state == ST_IDLE) && (req_valid || pending);
  assign in_data = (state == ST_DATA);

  // NONSEQ lasts exactly one cycle, then the data phase waits on HREADY
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      state  <= ST_IDLE;
      HTRANS <= `HTRANS_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state  <= ST_ADDR;
            HTRANS <= `HTRANS_NONSEQ;
          end
        end
        ST_ADDR: begin
          state  <= ST_DATA;
          HTRANS <= `HTRANS_IDLE;
        end
        ST_DATA: begin
          if (HREADY) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state  <= ST_IDLE;
          HTRANS <= `HTRANS_IDLE;
        end
      endcase
    end
  end

  // Keep a late request until the FSM is back in idle
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      pending <= 1'b0;
    end else if (start) begin
      pending <= 1'b0;
    end else if (req_valid) begin
      pending <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data registers
  ////////////////////////////////////////////////////////////////////////////

  // Address-phase record, held until the next transfer starts
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      addr_rec <= '0;
    end else if (start) begin
      addr_rec.haddr  <= req.addr;
      addr_rec.hwrite <= req.write;
      addr_rec.hsize  <= req.hsize;
    end
  end

  assign HADDR  = addr_rec.haddr;
  assign HWRITE = addr_rec.hwrite;
  assign HSIZE  = addr_rec.hsize;

  // Write data loaded early, stable across the whole data phase
  always_ff @(posedge HCLK) begin
    if (start) begin
      HWDATA <= req.wdata;
    end
  end

  // Acknowledge is the data-phase cycle with HREADY high
  // On an ERROR response this is the second cycle, where HRESP is still set
  assign ack = in_data & HREADY;
  assign err = in_data & HRESP;

endmodule

// ==== dbg_ahb_pkg.sv ====
`include "dbg_ahb_macros.svh"

package dbg_ahb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Payload types for the two clock crossings
  ////////////////////////////////////////////////////////////////////////////

  // Debug command as it travels into the HCLK domain
  typedef struct packed {
    logic [`DBG_AHB_ADDR_W-1:0] addr;
    // Already replicated across all byte lanes
    logic [`DBG_AHB_DATA_W-1:0] wdata;
    logic                       write;
    logic [2:0]                 hsize;
  } biu_req_t;

  // Response on its way back to the debug clock domain
  typedef struct packed {
    // Aligned to the low lanes and zero-extended
    logic [`DBG_AHB_DATA_W-1:0] rdata;
    logic                       err;
  } biu_rsp_t;

  // Address-phase record, kept by the master through the data phase
  typedef struct packed {
    logic [`DBG_AHB_ADDR_W-1:0] haddr;
    logic                       hwrite;
    logic [2:0]                 hsize;
  } ahb_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Debug word size in bytes to HSIZE code
  // Sizes other than 1 or 2 fall back to a full word
  function automatic logic [2:0] size_to_hsize(input logic [3:0] word_size);
    case (word_size)
      4'd1:    return `HSIZE_BYTE;
      4'd2:    return `HSIZE_HWORD;
      default: return `HSIZE_WORD;
    endcase
  endfunction

endpackage

// ==== dbg_ahb_slave_model.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_ahb_slave_model (
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  input  logic [`DBG_AHB_ADDR_W-1:0] HADDR,
  input  logic                       HWRITE,
  input  logic [2:0]                 HSIZE,
  input  logic [1:0]                 HTRANS,
  input  logic [`DBG_AHB_DATA_W-1:0] HWDATA,
  input  logic [1:0]                 wait_cycles,
  output logic [`DBG_AHB_DATA_W-1:0] HRDATA,
  output logic                       HREADY,
  output logic                       HRESP
);

  // Everything from here up answers with ERROR
  localparam logic [`DBG_AHB_ADDR_W-1:0] ERR_BASE = 32'h0000_0100;

  logic [`DBG_AHB_DATA_W-1:0] mem [0:15];

  // Data-phase context captured at the address phase
  logic                       dp_active;
  logic                       dp_write;
  logic                       dp_err;
  logic [`DBG_AHB_ADDR_W-1:0] dp_addr;
  logic [2:0]                 dp_size;
  logic [1:0]                 wait_cnt;
  logic [3:0]                 lane_en;

  // Byte lanes touched by the write, little-endian
  always_comb begin
    case (dp_size)
      `HSIZE_BYTE:  lane_en = 4'b0001 << dp_addr[1:0];
      `HSIZE_HWORD: lane_en = dp_addr[1] ? 4'b1100 : 4'b0011;
      default:      lane_en = 4'b1111;
    endcase
  end

  // Read data only while a good read sits in its data phase
  assign HRDATA = (dp_active && !dp_write && !dp_err) ? mem[dp_addr[5:2]] : '0;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dp_active <= 1'b0;
      dp_write  <= 1'b0;
      dp_err    <= 1'b0;
      dp_addr   <= '0;
      dp_size   <= '0;
      wait_cnt  <= '0;
      HREADY    <= 1'b1;
      HRESP     <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (dp_active) begin
        if (HREADY) begin
          // Data phase done, commit a write lane by lane
          dp_active <= 1'b0;
          HRESP     <= 1'b0;
          if (dp_write && !dp_err) begin
            for (int b = 0; b < 4; b++) begin
              if (lane_en[b]) begin
                mem[dp_addr[5:2]][8*b +: 8] <= HWDATA[8*b +: 8];
              end
            end
          end
        end else if (dp_err) begin
          // Second cycle of the ERROR response
          HREADY <= 1'b1;
        end else begin
          HREADY   <= (wait_cnt == 2'd1);
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
      // New address phase, master never overlaps it with a data phase
      if (HREADY && HTRANS == `HTRANS_NONSEQ) begin
        dp_active <= 1'b1;
        dp_addr   <= HADDR;
        dp_write  <= HWRITE;
        dp_size   <= HSIZE;
        dp_err    <= (HADDR >= ERR_BASE);
        if (HADDR >= ERR_BASE) begin
          HREADY <= 1'b0;
          HRESP  <= 1'b1;
        end else begin
          HREADY   <= (wait_cycles == 2'd0);
          wait_cnt <= wait_cycles;
        end
      end
    end
  end

endmodule

// ==== dbg_ahb_tb.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_ahb_tb;

  // One trace line
  typedef struct packed {
    logic [7:0]                 op;
    logic [`DBG_AHB_ADDR_W-1:0] addr;
    logic [3:0]                 size;
    logic [`DBG_AHB_DATA_W-1:0] wdata;
    logic [`DBG_AHB_DATA_W-1:0] rdata;
    logic                       err;
  } trace_entry_t;

  logic                       HCLK;
  logic                       biu_clk;
  logic                       ahb_rstn;
  // Debug port
  logic [`DBG_AHB_ADDR_W-1:0] biu_addr;
  logic [`DBG_AHB_DATA_W-1:0] biu_wdata;
  logic                       biu_write;
  logic [3:0]                 biu_word_size;
  logic                       biu_strb;
  logic                       biu_rdy;
  logic [`DBG_AHB_DATA_W-1:0] biu_rdata;
  logic                       biu_err;
  // AHB port
  logic [`DBG_AHB_ADDR_W-1:0] HADDR;
  logic                       HWRITE;
  logic [2:0]                 HSIZE;
  logic [1:0]                 HTRANS;
  logic [`DBG_AHB_DATA_W-1:0] HWDATA;
  logic [`DBG_AHB_DATA_W-1:0] HRDATA;
  logic                       HREADY;
  logic                       HRESP;

  // Wait-state source for the slave
  logic [31:0]  rng_state   = 32'h047d2314;
  logic [1:0]   wait_cycles = 2'd0;

  trace_entry_t trace_q[$];
  logic         loaded      = 1'b0;
  longint       watchdog_ns = 0;

  dbg_ahb_clkgen u_clkgen (
    .HCLK     (HCLK),
    .biu_clk  (biu_clk),
    .ahb_rstn (ahb_rstn)
  );

  dbg_ahb_bridge UUT (
    .biu_clk       (biu_clk),
    .biu_addr      (biu_addr),
    .biu_wdata     (biu_wdata),
    .biu_write     (biu_write),
    .biu_word_size (biu_word_size),
    .biu_strb      (biu_strb),
    .biu_rdy       (biu_rdy),
    .biu_rdata     (biu_rdata),
    .biu_err       (biu_err),
    .HCLK          (HCLK),
    .HADDR         (HADDR),
    .HWRITE        (HWRITE),
    .HSIZE         (HSIZE),
    .HTRANS        (HTRANS),
    .HWDATA        (HWDATA),
    .HRDATA        (HRDATA),
    .HREADY        (HREADY),
    .HRESP         (HRESP),
    .ahb_rstn      (ahb_rstn)
  );

  dbg_ahb_slave_model u_slave (
    .HCLK        (HCLK),
    .ahb_rstn    (ahb_rstn),
    .HADDR       (HADDR),
    .HWRITE      (HWRITE),
    .HSIZE       (HSIZE),
    .HTRANS      (HTRANS),
    .HWDATA      (HWDATA),
    .wait_cycles (wait_cycles),
    .HRDATA      (HRDATA),
    .HREADY      (HREADY),
    .HRESP       (HRESP)
  );

  // Protocol checks inside the bridge
  bind dbg_ahb_bridge dbg_ahb_asserts u_asserts (
    .HCLK     (HCLK),
    .biu_clk  (biu_clk),
    .ahb_rstn (ahb_rstn),
    .HTRANS   (HTRANS),
    .HADDR    (HADDR),
    .HWRITE   (HWRITE),
    .HSIZE    (HSIZE),
    .HREADY   (HREADY),
    .biu_strb (biu_strb),
    .biu_rdy  (biu_rdy)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // New wait count every HCLK for the slave's next address phase
  always @(negedge HCLK) begin
    rng_state = xorshift32(rng_state);
    wait_cycles <= rng_state[1:0];
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("Error: time %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Lines starting with # are comments
  // Columns are op addr size wdata rdata err
  task automatic load_trace();
    int           fd;
    int           code;
    string        line;
    trace_entry_t e;
    logic [7:0]   op;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  rdata;
    int           size;
    int           err;
    fd = $fopen("dbg_ahb_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file dbg_ahb_trace.txt");
      $display("CHECKS FAILED");
      $fatal(1, "no trace file");
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%c %h %d %h %h %d", op, addr, size, wdata, rdata, err);
        if (code != 6) begin
          $display("Trace line could not be parsed: %s", line);
          $display("CHECKS FAILED");
          $fatal(1, "bad trace line");
        end
        e.op    = op;
        e.addr  = addr;
        e.size  = size[3:0];
        e.wdata = wdata;
        e.rdata = rdata;
        e.err   = err[0];
        trace_q.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // Issue one command at a falling edge as soon as biu_rdy is high
  task automatic run_entry(input trace_entry_t e, input int idx);
    while (biu_rdy !== 1'b1) @(negedge biu_clk);
    biu_addr      = e.addr;
    biu_wdata     = e.wdata;
    biu_write     = (e.op == "W");
    biu_word_size = e.size;
    biu_strb      = 1'b1;
    @(negedge biu_clk);
    biu_strb = 1'b0;
    // X lines add a write strobe while busy that must be dropped
    if (e.op == "X") begin
      check_value(biu_rdy, 1'b0, $sformatf("line %0d biu_rdy while busy", idx));
      biu_write     = 1'b1;
      biu_word_size = 4'd4;
      biu_strb      = 1'b1;
      @(negedge biu_clk);
      biu_strb = 1'b0;
    end
    while (biu_rdy !== 1'b1) @(negedge biu_clk);
    check_value(biu_err, e.err, $sformatf("line %0d biu_err", idx));
    // Read data means nothing after a write or an ERROR
    if (e.op != "W" && !e.err) begin
      check_value(biu_rdata, e.rdata, $sformatf("line %0d biu_rdata", idx));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    biu_addr      = '0;
    biu_wdata     = '0;
    biu_write     = 1'b0;
    biu_word_size = 4'd4;
    biu_strb      = 1'b0;
    load_trace();
    // 400 ns per line plus room for reset
    watchdog_ns = trace_q.size() * 400 + 200;
    loaded = 1'b1;
    wait (ahb_rstn === 1'b1);
    // Let the per-domain reset synchronizers release
    repeat (4) @(negedge biu_clk);
    for (int i = 0; i < trace_q.size(); i++) begin
      run_entry(trace_q[i], i);
    end
    repeat (4) @(negedge biu_clk);
    if (UUT.u_asserts.violation_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #(watchdog_ns);
    $display("The bridge stopped responding, biu_rdy did not return within %0d ns",
             watchdog_ns);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== dbg_ahb_trace.txt ====
# op addr size wdata expected_rdata expected_err, all values hex except size and err
# op W write, R read, X read with a write strobed while busy that must be ignored
W 00000010 4 a5b4c3d2 00000000 0
R 00000010 4 00000000 a5b4c3d2 0
W 00000020 1 00000011 00000000 0
W 00000021 1 00000022 00000000 0
W 00000022 1 00000033 00000000 0
W 00000023 1 00000044 00000000 0
R 00000020 4 00000000 44332211 0
W 00000024 4 ffffffff 00000000 0
W 00000026 1 0000005a 00000000 0
R 00000024 4 00000000 ff5affff 0
W 00000032 2 0000beef 00000000 0
R 00000030 4 00000000 beef0000 0
R 00000010 1 00000000 000000d2 0
R 00000013 1 00000000 000000a5 0
R 00000011 1 00000000 000000c3 0
R 00000012 2 00000000 0000a5b4 0
R 00000010 2 00000000 0000c3d2 0
W 00000100 4 12345678 00000000 1
R 00000104 4 00000000 00000000 1
R 00000010 4 00000000 a5b4c3d2 0
X 00000020 4 deadbeef 44332211 0
R 00000020 4 00000000 44332211 0

// ==== dbg_biu_front.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_biu_front (
  input  logic                       biu_clk,
  input  logic                       ahb_rstn,
  input  logic [`DBG_AHB_ADDR_W-1:0] biu_addr,
  input  logic [`DBG_AHB_DATA_W-1:0] biu_wdata,
  input  logic                       biu_write,
  input  logic [3:0]                 biu_word_size,
  input  logic                       biu_strb,
  output logic                       biu_rdy,
  output logic [`DBG_AHB_DATA_W-1:0] biu_rdata,
  output logic                       biu_err,
  output logic                       req_load,
  output dbg_ahb_pkg::biu_req_t      req,
  input  logic                       rsp_valid,
  input  dbg_ahb_pkg::biu_rsp_t      rsp
);

  // Debug domain reset release
  logic [1:0] rst_sync;
  logic       rstn;

  // Strobe taken only while ready
  logic       accept;

  always_ff @(posedge biu_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rstn = rst_sync[1];

  ////////////////////////////////////////////////////////////////////////////
  // Command side
  ////////////////////////////////////////////////////////////////////////////

  // A strobe while busy is dropped, biu_rdy is the only back-pressure
  assign accept   = biu_strb & biu_rdy;
  assign req_load = accept;

  // Request payload, latched by the crossing on req_load
  always_comb begin
    req.addr  = biu_addr;
    req.write = biu_write;
    req.hsize = dbg_ahb_pkg::size_to_hsize(biu_word_size);
    // Copy narrow write data onto every lane, the slave picks its lanes
    case (biu_word_size)
      4'd1:    req.wdata = {4{biu_wdata[7:0]}};
      4'd2:    req.wdata = {2{biu_wdata[15:0]}};
      default: req.wdata = biu_wdata;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  // Ready drops on accept and comes back with the response
  always_ff @(posedge biu_clk or negedge rstn) begin
    if (!rstn) begin
      biu_rdy <= 1'b1;
      biu_err <= 1'b0;
    end else if (accept) begin
      biu_rdy <= 1'b0;
    end else if (rsp_valid) begin
      biu_rdy <= 1'b1;
      biu_err <= rsp.err;
    end
  end

  // Read data, valid while biu_rdy is high
  always_ff @(posedge biu_clk) begin
    if (rsp_valid) begin
      biu_rdata <= rsp.rdata;
    end
  end

endmodule

// ==== dbg_rdata_align.sv ====
`timescale 1ns/1ps
`include "dbg_ahb_macros.svh"

module dbg_rdata_align (
  input  logic                       HCLK,
  input  logic                       ahb_rstn,
  input  logic                       ack,
  input  dbg_ahb_pkg::ahb_addr_t     addr_rec,
  input  logic                       err,
  input  logic [`DBG_AHB_DATA_W-1:0] HRDATA,
  output logic                       rsp_valid,
  output dbg_ahb_pkg::biu_rsp_t      rsp
);

  logic [1:0]                 rst_sync;
  logic                       rstn;

  // Lane selection from the low address bits
  logic [1:0]                 byte_off;
  logic [1:0]                 byte_lane;
  logic                       half_lane;
  logic [`DBG_AHB_DATA_W-1:0] rdata_sel;

  always_ff @(posedge HCLK or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rstn = rst_sync[1];

  // Big-endian lanes count down from the top of the word
  assign byte_off  = addr_rec.haddr[1:0];
  assign byte_lane = (`DBG_AHB_LITTLE_ENDIAN != 0) ? byte_off : ~byte_off;
  assign half_lane = (`DBG_AHB_LITTLE_ENDIAN != 0) ? byte_off[1] : ~byte_off[1];

  // Move the addressed lane down and zero-extend
  always_comb begin
    rdata_sel = '0;
    case (addr_rec.hsize)
      `HSIZE_BYTE:  rdata_sel[7:0]  = HRDATA[{byte_lane, 3'b000} +: 8];
      `HSIZE_HWORD: rdata_sel[15:0] = HRDATA[{half_lane, 4'b0000} +: 16];
      default:      rdata_sel       = HRDATA;
    endcase
  end

  // Response captured on the acknowledge
  always_ff @(posedge HCLK) begin
    if (ack) begin
      rsp.rdata <= rdata_sel;
      rsp.err   <= err;
    end
  end

  // One-cycle strobe right behind the acknowledge
  always_ff @(posedge HCLK or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= ack;
    end
  end

endmodule

// ==== dbg_toggle_xfer.sv ====
`timescale 1ns/1ps

module dbg_toggle_xfer #(
  parameter type payload_t = logic
) (
  input  logic     src_clk,
  input  logic     dst_clk,
  input  logic     ahb_rstn,
  input  logic     src_load,
  input  payload_t src_data,
  output logic     dst_valid,
  output payload_t dst_data
);

  // Reset release, one synchronizer per domain
  logic [1:0] src_rst_sync;
  logic [1:0] dst_rst_sync;
  logic       src_rstn;
  logic       dst_rstn;

  // Source side toggle and held payload
  logic       src_toggle;
  payload_t   src_hold;

  // Destination side toggle synchronizer and edge detect flop
  logic       dst_sync1;
  logic       dst_sync2;
  logic       dst_sync3;

  always_ff @(posedge src_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      src_rst_sync <= 2'b00;
    end else begin
      src_rst_sync <= {src_rst_sync[0], 1'b1};
    end
  end

  always_ff @(posedge dst_clk or negedge ahb_rstn) begin
    if (!ahb_rstn) begin
      dst_rst_sync <= 2'b00;
    end else begin
      dst_rst_sync <= {dst_rst_sync[0], 1'b1};
    end
  end

  assign src_rstn = src_rst_sync[1];
  assign dst_rstn = dst_rst_sync[1];

  ////////////////////////////////////////////////////////////////////////////
  // Source clock domain
  ////////////////////////////////////////////////////////////////////////////

  // Payload stays put until the next load, so the far side can sample it late
  always_ff @(posedge src_clk) begin
    if (src_load) begin
      src_hold <= src_data;
    end
  end

  // Every load is one toggle of the level crossing over
  always_ff @(posedge src_clk or negedge src_rstn) begin
    if (!src_rstn) begin
      src_toggle <= 1'b0;
    end else if (src_load) begin
      src_toggle <= ~src_toggle;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Destination clock domain
  ////////////////////////////////////////////////////////////////////////////

  // Two flops against metastability, a third to find the toggle edge
  // dst_valid is registered, giving three dst_clk edges of latency
  always_ff @(posedge dst_clk or negedge dst_rstn) begin
    if (!dst_rstn) begin
      dst_sync1 <= 1'b0;
      dst_sync2 <= 1'b0;
      dst_sync3 <= 1'b0;
      dst_valid <= 1'b0;
    end else begin
      dst_sync1 <= src_toggle;
      dst_sync2 <= dst_sync1;
      dst_sync3 <= dst_sync2;
      dst_valid <= dst_sync2 ^ dst_sync3;
    end
  end

  // Held payload is stable by the time the toggle edge shows up
  always_ff @(posedge dst_clk) begin
    if (dst_sync2 ^ dst_sync3) begin
      dst_data <= src_hold;
    end
  end

endmodule

// ==== list.f ====
+incdir+.
dbg_ahb_pkg.sv
dbg_toggle_xfer.sv
dbg_biu_front.sv
dbg_ahb_master.sv
dbg_rdata_align.sv
dbg_ahb_bridge.sv
dbg_ahb_clkgen.sv
dbg_ahb_slave_model.sv
dbg_ahb_asserts.sv
dbg_ahb_tb.sv
